/* Bender.yml */
package:
  name: led_periph

sources:
  - files:
      - source/axil_pkg.sv
      - source/led_regmap_pkg.sv
      - source/axil_reg_port.sv
      - source/led_channel.sv
      - source/reg_read_mux.sv
      - source/led_periph_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_led_periph.sv

/* flist.f */
+incdir+include
source/axil_pkg.sv
source/led_regmap_pkg.sv
source/axil_reg_port.sv
source/led_channel.sv
source/reg_read_mux.sv
source/led_periph_top.sv
verif/tb_led_periph.sv

/* source/axil_pkg.sv */
package axil_pkg;

    // bus geometry
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // byte offset bits below the word address
    localparam int ADDR_LSB = $clog2(STRB_W);
    localparam int WORD_W   = ADDR_W - ADDR_LSB;

    // byte address as seen on awaddr / araddr
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [STRB_W-1:0] strb_t;

    // word address, byte offset stripped
    typedef logic [WORD_W-1:0] word_addr_t;

    // bresp / rresp encoding
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* source/axil_reg_port.sv */
`timescale 1ns/1ps

module axil_reg_port (
    input  logic                     clk,
    input  logic                     rst_n,

    // write address / data
    input  axil_pkg::addr_t          awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  axil_pkg::data_t          wdata,
    input  axil_pkg::strb_t          wstrb,
    input  logic                     wvalid,
    output logic                     wready,

    // write response
    output axil_pkg::resp_t          bresp,
    output logic                     bvalid,
    input  logic                     bready,

    // read address / data
    input  axil_pkg::addr_t          araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output axil_pkg::data_t          rdata,
    output axil_pkg::resp_t          rresp,
    output logic                     rvalid,
    input  logic                     rready,

    // register side
    output logic                     wr_en,
    output led_regmap_pkg::led_idx_t wr_idx,
    output axil_pkg::data_t          wr_data,
    output axil_pkg::strb_t          wr_strb,
    output logic                     rd_en,
    output led_regmap_pkg::led_idx_t rd_idx,
    input  axil_pkg::data_t          rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        WR_RESP,
        RD_RESP
    } state_e;

    state_e               state_q;
    state_e               state_d;
    axil_pkg::word_addr_t aw_word;
    axil_pkg::word_addr_t ar_word;
    logic                 wr_req;
    logic                 wr_ok;
    logic                 rd_hs;
    logic                 rd_ok;
    axil_pkg::resp_t      bresp_q;
    axil_pkg::resp_t      rresp_q;

    // word decode, byte offset ignored
    assign aw_word = awaddr[axil_pkg::ADDR_W-1:axil_pkg::ADDR_LSB];
    assign ar_word = araddr[axil_pkg::ADDR_W-1:axil_pkg::ADDR_LSB];
    assign wr_idx  = led_regmap_pkg::led_idx_t'(aw_word);
    assign rd_idx  = led_regmap_pkg::led_idx_t'(ar_word);

    // status sits right after the ctrl words and is read only
    assign wr_ok = (aw_word < led_regmap_pkg::STATUS_IDX);
    assign rd_ok = (ar_word <= led_regmap_pkg::STATUS_IDX);

    // address and data are taken together, write wins over read
    assign wr_req  = (state_q == IDLE) && awvalid && wvalid;
    assign awready = wr_req;
    assign wready  = wr_req;
    assign arready = (state_q == IDLE) && !(awvalid && wvalid);
    assign rd_hs   = arvalid && arready;

    // strobes only for legal accesses
    assign wr_en   = wr_req && wr_ok;
    assign wr_data = wdata;
    assign wr_strb = wstrb;
    assign rd_en   = rd_hs && rd_ok;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (wr_req) begin
                    state_d = WR_RESP;
                end else if (rd_hs) begin
                    state_d = RD_RESP;
                end
            end
            WR_RESP: begin
                if (bready) begin
                    state_d = IDLE;
                end
            end
            RD_RESP: begin
                if (rready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            bresp_q <= axil_pkg::RESP_OKAY;
            rresp_q <= axil_pkg::RESP_OKAY;
        end else begin
            state_q <= state_d;
            if (wr_req) begin
                bresp_q <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
            end
            if (rd_hs) begin
                rresp_q <= rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
            end
        end
    end

    assign bvalid = (state_q == WR_RESP);
    assign bresp  = bresp_q;
    assign rvalid = (state_q == RD_RESP);
    assign rresp  = rresp_q;

    // error reads return zero, the mux was not loaded
    assign rdata = (rresp_q == axil_pkg::RESP_SLVERR) ? '0 : rd_data;

    // one response channel at a time
    a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
        !(bvalid && rvalid));

    // a stalled response holds, incl. the data registered in the read mux
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

endmodule

/* source/led_channel.sv */
`timescale 1ns/1ps

module led_channel (
    input  logic                     clk,
    input  logic                     rst_n,
    input  led_regmap_pkg::led_idx_t chan_idx,
    input  logic                     wr_en,
    input  led_regmap_pkg::led_idx_t wr_idx,
    input  axil_pkg::data_t          wr_data,
    input  axil_pkg::strb_t          wr_strb,
    output axil_pkg::data_t          ctrl_q,
    output logic                     led_level
);

    logic                                   sel_wr;
    axil_pkg::data_t                        ctrl_d;
    led_regmap_pkg::led_mode_e              mode;
    led_regmap_pkg::half_period_t           half;
    logic [led_regmap_pkg::PRESCALE_W-1:0]  pre_cnt;
    led_regmap_pkg::half_period_t           hp_cnt;
    logic                                   tick;
    logic                                   blink_q;

    assign sel_wr = wr_en && (wr_idx == chan_idx);

    // byte lanes under strobe, unimplemented bits forced to zero
    always_comb begin
        ctrl_d = ctrl_q;
        for (int b = 0; b < axil_pkg::STRB_W; b++) begin
            if (wr_strb[b]) begin
                ctrl_d[8*b +: 8] = wr_data[8*b +: 8];
            end
        end
        ctrl_d = ctrl_d & led_regmap_pkg::CTRL_MASK;
    end

    assign mode = led_regmap_pkg::led_mode_e'(
        ctrl_q[led_regmap_pkg::MODE_LSB +: $bits(led_regmap_pkg::led_mode_e)]);
    assign half = ctrl_q[led_regmap_pkg::HALF_LSB +: $bits(led_regmap_pkg::half_period_t)];

    assign tick = (pre_cnt == led_regmap_pkg::PRESCALE_W'(led_regmap_pkg::BLINK_PRESCALE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q  <= '0;
            pre_cnt <= '0;
            hp_cnt  <= '0;
            blink_q <= 1'b0;
        end else if (sel_wr) begin
            // any write restarts the blink phase from low
            ctrl_q  <= ctrl_d;
            pre_cnt <= '0;
            hp_cnt  <= '0;
            blink_q <= 1'b0;
        end else if (mode == led_regmap_pkg::LED_BLINK) begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick) begin
                if (hp_cnt == half) begin
                    hp_cnt  <= '0;
                    blink_q <= !blink_q;
                end else begin
                    hp_cnt <= hp_cnt + 1'b1;
                end
            end
        end
    end

    // reserved mode is treated as off
    always_comb begin
        unique case (mode)
            led_regmap_pkg::LED_ON:    led_level = 1'b1;
            led_regmap_pkg::LED_BLINK: led_level = blink_q;
            default:                   led_level = 1'b0;
        endcase
    end

    // blink phase never left high outside blink mode
    a_off_low: assert property (@(posedge clk) disable iff (!rst_n)
        (mode inside {led_regmap_pkg::LED_OFF, led_regmap_pkg::LED_RSVD})
        |-> !led_level && !blink_q);

endmodule

/* source/led_periph_top.sv */
`timescale 1ns/1ps

module led_periph_top (
    input  logic                                clk,
    input  logic                                rst_n,

    input  axil_pkg::addr_t                     awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  axil_pkg::data_t                     wdata,
    input  axil_pkg::strb_t                     wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output axil_pkg::resp_t                     bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  axil_pkg::addr_t                     araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output axil_pkg::data_t                     rdata,
    output axil_pkg::resp_t                     rresp,
    output logic                                rvalid,
    input  logic                                rready,

    output logic [led_regmap_pkg::NUM_LEDS-1:0] led
);

    logic                     wr_en;
    led_regmap_pkg::led_idx_t wr_idx;
    axil_pkg::data_t          wr_data;
    axil_pkg::strb_t          wr_strb;
    logic                     rd_en;
    led_regmap_pkg::led_idx_t rd_idx;
    axil_pkg::data_t          rd_data;
    axil_pkg::data_t          ctrl_q [led_regmap_pkg::NUM_LEDS];

    axil_reg_port u_reg_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    // one channel per led, index doubles as register index
    for (genvar i = 0; i < led_regmap_pkg::NUM_LEDS; i++) begin : g_chan
        led_channel u_led_channel (
            .clk       (clk),
            .rst_n     (rst_n),
            .chan_idx  (led_regmap_pkg::led_idx_t'(i)),
            .wr_en     (wr_en),
            .wr_idx    (wr_idx),
            .wr_data   (wr_data),
            .wr_strb   (wr_strb),
            .ctrl_q    (ctrl_q[i]),
            .led_level (led[i])
        );
    end

    reg_read_mux u_read_mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .ctrl_q    (ctrl_q),
        .led_level (led),
        .rd_data   (rd_data)
    );

endmodule

/* source/led_regmap_pkg.sv */
package led_regmap_pkg;

    // channel count
    localparam int NUM_LEDS = 4;

    // register index, one per 32-bit word
    // 0..3 are channel ctrl at 0x00..0x0C, 4 is status at 0x10
    typedef logic [2:0] led_idx_t;

    localparam led_idx_t STATUS_IDX = 3'd4;

    // ctrl[1:0] mode
    typedef enum logic [1:0] {
        LED_OFF   = 2'd0,
        LED_ON    = 2'd1,
        LED_BLINK = 2'd2,
        LED_RSVD  = 2'd3
    } led_mode_e;

    // ctrl[15:8] blink half period, in prescaled ticks minus one
    typedef logic [7:0] half_period_t;

    // field positions inside a ctrl word
    localparam int MODE_LSB = 0;
    localparam int HALF_LSB = 8;

    // implemented ctrl bits, the rest read back as zero
    localparam axil_pkg::data_t CTRL_MASK = 32'h0000_ff03;

    // clock cycles per blink tick
    localparam int BLINK_PRESCALE = 16;
    localparam int PRESCALE_W     = $clog2(BLINK_PRESCALE);

endpackage

/* source/reg_read_mux.sv */
`timescale 1ns/1ps

module reg_read_mux (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                rd_en,
    input  led_regmap_pkg::led_idx_t            rd_idx,
    input  axil_pkg::data_t                     ctrl_q [led_regmap_pkg::NUM_LEDS],
    input  logic [led_regmap_pkg::NUM_LEDS-1:0] led_level,
    output axil_pkg::data_t                     rd_data
);

    axil_pkg::data_t status_word;
    axil_pkg::data_t sel_word;

    // led levels in the low bits, zero above
    assign status_word = axil_pkg::data_t'(led_level);

    always_comb begin
        sel_word = '0;
        if (rd_idx == led_regmap_pkg::STATUS_IDX) begin
            sel_word = status_word;
        end else begin
            for (int i = 0; i < led_regmap_pkg::NUM_LEDS; i++) begin
                if (rd_idx == led_regmap_pkg::led_idx_t'(i)) begin
                    sel_word = ctrl_q[i];
                end
            end
        end
    end

    // held until the next accepted read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= sel_word;
        end
    end

endmodule

/* include/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// bus master tasks, inputs change DRIVE_DLY after the rising edge
// ready and valid are sampled at the falling edge

task automatic wait_cycles(input int n);
    if (n > 0) begin
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    end
endtask

task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                          input axil_pkg::strb_t strb, input int stall);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!(awready && wready) && n < TIMEOUT_CYC) begin
        @(negedge clk);
        n++;
    end
    if (!(awready && wready)) begin
        report_timeout($sformatf("write to 0x%02h was never accepted", addr));
        awvalid = 1'b0;
        wvalid  = 1'b0;
        return;
    end
    @(posedge clk);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // hold off the response for a while
    wait_cycles(stall);
    bready = 1'b1;
    n = 0;
    @(negedge clk);
    while (!bvalid && n < TIMEOUT_CYC) begin
        @(negedge clk);
        n++;
    end
    if (!bvalid) begin
        report_timeout($sformatf("no write response for 0x%02h", addr));
    end else begin
        @(posedge clk);
        #DRIVE_DLY;
    end
    bready = 1'b0;
endtask

task automatic axil_read(input axil_pkg::addr_t addr, input int stall);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!arready && n < TIMEOUT_CYC) begin
        @(negedge clk);
        n++;
    end
    if (!arready) begin
        report_timeout($sformatf("read of 0x%02h was never accepted", addr));
        arvalid = 1'b0;
        return;
    end
    @(posedge clk);
    #DRIVE_DLY;
    arvalid = 1'b0;
    wait_cycles(stall);
    rready = 1'b1;
    n = 0;
    @(negedge clk);
    while (!rvalid && n < TIMEOUT_CYC) begin
        @(negedge clk);
        n++;
    end
    if (!rvalid) begin
        report_timeout($sformatf("no read data for 0x%02h", addr));
    end else begin
        @(posedge clk);
        #DRIVE_DLY;
    end
    rready = 1'b0;
endtask

`endif

/* verif/tb_led_periph.sv */
`timescale 1ns/1ps

module tb_led_periph;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int RST_CYCLES  = 10;
    localparam int TIMEOUT_CYC = 64;
    localparam int NUM_LEDS    = led_regmap_pkg::NUM_LEDS;

    logic                clk;
    logic                rst_n;
    axil_pkg::addr_t     awaddr;
    logic                awvalid;
    logic                awready;
    axil_pkg::data_t     wdata;
    axil_pkg::strb_t     wstrb;
    logic                wvalid;
    logic                wready;
    axil_pkg::resp_t     bresp;
    logic                bvalid;
    logic                bready;
    axil_pkg::addr_t     araddr;
    logic                arvalid;
    logic                arready;
    axil_pkg::data_t     rdata;
    axil_pkg::resp_t     rresp;
    logic                rvalid;
    logic                rready;
    logic [NUM_LEDS-1:0] led;

    // expected register contents and cycles since each channel's last write
    axil_pkg::data_t     exp_ctrl [NUM_LEDS];
    int                  since_wr [NUM_LEDS];
    logic [NUM_LEDS-1:0] exp_led;
    axil_pkg::data_t     exp_rdata;
    axil_pkg::resp_t     exp_bresp;
    axil_pkg::resp_t     exp_rresp;
    int                  aw_word;
    int                  ar_word;
    int                  mismatch_cnt = 0;
    int                  fail_cnt     = 0;
    int                  timeout_cnt  = 0;
    integer              seed;

    led_periph_top u_led_periph_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .led     (led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        mismatch_cnt++;
        $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                 $time, name, exp_v, got_v);
    endtask

    task automatic report_failure(input string what);
        fail_cnt++;
        $display("ERROR time=%0t %s", $time, what);
    endtask

    task automatic report_timeout(input string what);
        timeout_cnt++;
        $display("TIMEOUT time=%0t %s", $time, what);
    endtask

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // strobed lanes come from the new word, only implemented ctrl bits kept
    function automatic axil_pkg::data_t merge_bytes(input axil_pkg::data_t old_v,
                                                    input axil_pkg::data_t new_v,
                                                    input axil_pkg::strb_t strb);
        axil_pkg::data_t lanes;
        for (int b = 0; b < 4; b++) begin
            lanes[8*b +: 8] = {8{strb[b]}};
        end
        return ((old_v & ~lanes) | (new_v & lanes)) & led_regmap_pkg::CTRL_MASK;
    endfunction

    `include "tb_axil_tasks.svh"

    assign aw_word = int'(awaddr) / 4;
    assign ar_word = int'(araddr) / 4;

    // blink level flips once per (h+1) prescaled ticks, starting low at the write
    always_comb begin
        int period;
        for (int i = 0; i < NUM_LEDS; i++) begin
            period = (int'(exp_ctrl[i][15:8]) + 1) * led_regmap_pkg::BLINK_PRESCALE;
            case (led_regmap_pkg::led_mode_e'(exp_ctrl[i][1:0]))
                led_regmap_pkg::LED_ON:    exp_led[i] = 1'b1;
                led_regmap_pkg::LED_BLINK: exp_led[i] = ((since_wr[i] / period) % 2) == 1;
                default:                   exp_led[i] = 1'b0;
            endcase
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LEDS; i++) begin
                exp_ctrl[i] <= '0;
                since_wr[i] <= 0;
            end
            exp_rdata <= '0;
            exp_bresp <= axil_pkg::RESP_OKAY;
            exp_rresp <= axil_pkg::RESP_OKAY;
        end else begin
            for (int i = 0; i < NUM_LEDS; i++) begin
                since_wr[i] <= since_wr[i] + 1;
            end
            if (awvalid && awready && wvalid && wready) begin
                if (aw_word < NUM_LEDS) begin
                    exp_ctrl[aw_word] <= merge_bytes(exp_ctrl[aw_word], wdata, wstrb);
                    since_wr[aw_word] <= 0;
                    exp_bresp         <= axil_pkg::RESP_OKAY;
                end else begin
                    exp_bresp <= axil_pkg::RESP_SLVERR;
                end
            end
            if (arvalid && arready) begin
                // status word is at the index right after the last channel
                if (ar_word < NUM_LEDS) begin
                    exp_rdata <= exp_ctrl[ar_word];
                    exp_rresp <= axil_pkg::RESP_OKAY;
                end else if (ar_word == NUM_LEDS) begin
                    exp_rdata <= axil_pkg::data_t'(exp_led);
                    exp_rresp <= axil_pkg::RESP_OKAY;
                end else begin
                    exp_rdata <= '0;
                    exp_rresp <= axil_pkg::RESP_SLVERR;
                end
            end
        end
    end

    a_led: assert property (@(posedge clk) disable iff (!rst_n) led == exp_led)
        else report_mismatch("led", $sampled(exp_led), $sampled(led));
    a_rdata: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rdata == exp_rdata)
        else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));
    a_rresp: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rresp == exp_rresp)
        else report_mismatch("rresp", $sampled(exp_rresp), $sampled(rresp));
    a_bresp: assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> bresp == exp_bresp)
        else report_mismatch("bresp", $sampled(exp_bresp), $sampled(bresp));

    a_idle_after_rst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) |-> !bvalid && !rvalid)
        else report_failure("a response is pending right after reset");
    a_b_next: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && awready && wvalid && wready |=> bvalid)
        else report_failure("bvalid did not rise the cycle after the write handshake");
    a_r_next: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |=> rvalid)
        else report_failure("rvalid did not rise the cycle after the read handshake");
    a_b_stall: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else report_failure("write response changed while bready was low");
    a_r_stall: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
        else report_failure("read response changed while rready was low");
    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid || rvalid |-> !awready && !wready && !arready)
        else report_failure("a ready was high while a response was pending");
    a_wr_first: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && wvalid |-> !arready)
        else report_failure("read accepted while a write was pending");

    initial begin
        axil_pkg::data_t data;
        axil_pkg::addr_t bad_addr;
        int              stall_b;
        int              stall_r;
        seed    = 5;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        wait_cycles(2);

        // everything reads zero out of reset
        for (int i = 0; i <= NUM_LEDS; i++) begin
            axil_read(axil_pkg::addr_t'(4 * i), 0);
        end

        // full strobe write then a partial one, each read back
        for (int i = 0; i < NUM_LEDS; i++) begin
            axil_write(axil_pkg::addr_t'(4 * i), $random(seed), 4'hf, 0);
            axil_read(axil_pkg::addr_t'(4 * i), 0);
            axil_write(axil_pkg::addr_t'(4 * i), $random(seed),
                       axil_pkg::strb_t'(1 + rand_below(14)), 0);
            axil_read(axil_pkg::addr_t'(4 * i), 0);
        end

        // static modes, one channel at a time
        for (int i = 0; i < NUM_LEDS; i++) begin
            axil_write(axil_pkg::addr_t'(4 * i), 32'(led_regmap_pkg::LED_ON), 4'h1, 0);
            axil_write(axil_pkg::addr_t'(4 * i), 32'(led_regmap_pkg::LED_RSVD), 4'h1, 0);
            axil_write(axil_pkg::addr_t'(4 * i), 32'(led_regmap_pkg::LED_OFF), 4'h1, 0);
            axil_write(axil_pkg::addr_t'(4 * i), 32'(led_regmap_pkg::LED_ON), 4'h1, 0);
        end

        // all channels blinking with short random half periods
        for (int i = 0; i < NUM_LEDS; i++) begin
            data = (rand_below(8) << 8) | 32'(led_regmap_pkg::LED_BLINK);
            axil_write(axil_pkg::addr_t'(4 * i), data, 4'h3, 0);
        end
        for (int k = 0; k < 16; k++) begin
            wait_cycles(1 + rand_below(40));
            axil_read(8'h10, 0);
        end

        // status is read only, nothing lives at 0x14 and above
        axil_write(8'h10, 32'hffff_ffff, 4'hf, 0);
        // low index bits of 0x20 match channel 0
        axil_write(8'h20, 32'hffff_ffff, 4'hf, 0);
        for (int k = 0; k < 4; k++) begin
            bad_addr = axil_pkg::addr_t'(8'h14 + rand_below(236));
            axil_write(bad_addr, $random(seed), 4'hf, 0);
            axil_read(bad_addr, 0);
        end
        axil_read(8'hfc, 0);
        for (int i = 0; i <= NUM_LEDS; i++) begin
            axil_read(axil_pkg::addr_t'(4 * i), 0);
        end

        // stalled responses with a read queued behind each write
        for (int k = 0; k < NUM_LEDS; k++) begin
            data    = $random(seed);
            stall_b = 1 + rand_below(16);
            stall_r = 1 + rand_below(16);
            fork
                axil_write(axil_pkg::addr_t'(4 * k), data, 4'hf, stall_b);
                axil_read(axil_pkg::addr_t'(4 * k), stall_r);
            join
        end

        // stalled reads with a write queued behind each one
        for (int k = 0; k < NUM_LEDS; k++) begin
            data    = $random(seed);
            stall_r = 1 + rand_below(16);
            fork
                axil_read(axil_pkg::addr_t'(4 * k), stall_r);
                begin
                    wait_cycles(1);
                    axil_write(axil_pkg::addr_t'(4 * k), data, 4'hf, 0);
                end
            join
        end
        axil_read(8'h10, 1 + rand_below(16));
        wait_cycles(4);

        $display("errors: mismatches=%0d failures=%0d timeouts=%0d",
                 mismatch_cnt, fail_cnt, timeout_cnt);
        if (mismatch_cnt + fail_cnt + timeout_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
